// File: common/divIterIf.sv
////////////////////////////////////////////////////////////////////////////
// link between the iteration stage and the quotient unit
// remainder feedback out, stage sum and quotient bits back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface divIterIf import divPkg::*; #(
  parameter int unsigned MantW = divPkg::MantW
);

  // held state from the quotient unit
  logic [MantW:0]          PartRem;    // remainder, sign in msb
  logic                    QuotLsb;    // 1 -> first cell subtracts
  logic                    Load;       // first cell takes numerator

  // stage results
  logic [MantW:0]          StageRem;
  logic [BitsPerCycle-1:0] StageQuot;  // first cell in msb
  logic                    NextBit;    // rounding bit

  modport stage (
    input  PartRem, QuotLsb, Load,
    output StageRem, StageQuot, NextBit
  );

  modport quot (
    output PartRem, QuotLsb, Load,
    input  StageRem, StageQuot, NextBit
  );

endinterface

// File: common/divPkg.sv
////////////////////////////////////////////////////////////////////////////
// shared constants of the single-precision mantissa divider
// widths, exponent bias, stage size and iteration counter width
////////////////////////////////////////////////////////////////////////////

package divPkg;

  // mantissa incl. hidden bit
  localparam int unsigned MantW = 24;

  // biased exponent field
  localparam int unsigned ExpW = 8;

  // cells per stage, one quotient bit each
  localparam int unsigned BitsPerCycle = 4;

  localparam int unsigned ExpBias = 127;   // single precision

  // enough for MantW / BitsPerCycle iterations
  localparam int unsigned IterCntW = 3;

endpackage

// File: divider/iterStage.sv
////////////////////////////////////////////////////////////////////////////
// one non-restoring iteration stage
// four chained add/subtract cells, four quotient bits per pass
// plus the rounding bit from the held remainder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iterStage import divPkg::*; #(
  parameter int unsigned MantW = divPkg::MantW
) (
  input  logic [MantW-1:0] Numerator,
  input  logic [MantW-1:0] Denominator,
  divIterIf.stage          Iter
);

  localparam int unsigned RemW = MantW + 1;

  logic [RemW-1:0]                    denTrue;
  logic [RemW-1:0]                    denCmp;
  logic [BitsPerCycle-1:0][RemW-1:0]  cellA;
  logic [BitsPerCycle-1:0][RemW-1:0]  cellB;
  logic [BitsPerCycle-1:0][RemW-1:0]  cellSum;
  logic [BitsPerCycle-1:0]            cellCarry;  // index 0 is the first cell
  logic                               firstSub;

  assign denTrue = {1'b0, Denominator};
  assign denCmp  = ~denTrue;

  ////////////////////////////////////////////////////////////////////////////
  // first cell
  ////////////////////////////////////////////////////////////////////////////

  // numerator is always a subtract, otherwise the last quotient bit decides
  assign firstSub = Iter.Load | Iter.QuotLsb;
  assign cellA[0] = Iter.Load ? {1'b0, Numerator} : {Iter.PartRem[MantW-1:0], Iter.QuotLsb};
  assign cellB[0] = firstSub ? denCmp : denTrue;

  // the appended quotient bit supplies the +1 of a subtract, on load it comes in here
  assign {cellCarry[0], cellSum[0]} = {1'b0, cellA[0]} + {1'b0, cellB[0]}
                                      + {{RemW{1'b0}}, Iter.Load};

  ////////////////////////////////////////////////////////////////////////////
  // remaining cells
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 1; i < BitsPerCycle; i++)
  begin : gen_cell
    assign cellA[i] = {cellSum[i-1][MantW-1:0], cellCarry[i-1]};  // 2r + q
    assign cellB[i] = cellCarry[i-1] ? denCmp : denTrue;
    assign {cellCarry[i], cellSum[i]} = {1'b0, cellA[i]} + {1'b0, cellB[i]};
  end

  // carry out is the quotient bit, msb first
  for (genvar i = 0; i < BitsPerCycle; i++)
  begin : gen_quot
    assign Iter.StageQuot[BitsPerCycle-1-i] = cellCarry[i];
  end

  assign Iter.StageRem = cellSum[BitsPerCycle-1];
  assign Iter.NextBit  = cellCarry[0];  // one step past the held remainder

endmodule

// File: divider/quotientUnit.sv
////////////////////////////////////////////////////////////////////////////
// remainder and quotient registers of the divider
// quotient shift by one stage per clock, final rounding correction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module quotientUnit import divPkg::*; #(
  parameter int unsigned MantW = divPkg::MantW
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             Iterate,
  input  logic             LoadPulse,
  input  logic             DivBusy,
  divIterIf.quot           Iter,
  output logic [MantW-1:0] MantResult
);

  logic [MantW:0]   remQ;
  logic [MantW-1:0] quotQ;
  logic             roundBit;
  logic [MantW:0]   roundSum;
  logic             commit;

  // feedback into the first cell
  assign Iter.PartRem = remQ;
  assign Iter.QuotLsb = quotQ[0];
  assign Iter.Load    = LoadPulse;

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
      remQ <= '0;
    else if (Iterate)
      remQ <= Iter.StageRem;
  end

  ////////////////////////////////////////////////////////////////////////////
  // rounding
  ////////////////////////////////////////////////////////////////////////////

  assign roundBit = Iter.NextBit & DivBusy;
  assign roundSum = {1'b0, quotQ} + {{MantW{1'b0}}, roundBit};

  // keep the plain quotient if rounding would need an extra bit
  assign MantResult = roundSum[MantW] ? quotQ : roundSum[MantW-1:0];

  // done cycle, busy drops at the next edge
  assign commit = DivBusy & ~Iterate;

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      quotQ <= '0;
    end
    else if (Iterate)
    begin
      quotQ <= {quotQ[MantW-BitsPerCycle-1:0], Iter.StageQuot};
    end
    else if (commit)
    begin
      // fold the correction in so the result holds once busy is gone
      quotQ <= MantResult;
    end
  end

endmodule

// File: rtl/divCtrl.sv
////////////////////////////////////////////////////////////////////////////
// divider control
// start delay, busy level, iteration counter, done pulse and ready level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module divCtrl import divPkg::*; #(
  parameter int unsigned NumIter = divPkg::MantW / divPkg::BitsPerCycle
) (
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  logic Start,
  output logic LoadPulse,
  output logic Iterate,
  output logic DivBusy,
  output logic Ready,
  output logic Done
);

  logic [IterCntW-1:0] iterCnt;
  logic                lastIter;

  assign lastIter = (iterCnt == IterCntW'(NumIter - 1));
  assign Iterate  = LoadPulse | (|iterCnt);  // load cycle plus counting

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      LoadPulse <= 1'b0;
    end
    else
    begin
      LoadPulse <= Start;  // first iteration cycle
    end
  end

  // busy from start until done has been seen
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
      DivBusy <= 1'b0;
    else if (Start)
      DivBusy <= 1'b1;
    else if (Done)
      DivBusy <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // iteration counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
      iterCnt <= '0;
    else if (lastIter)
      iterCnt <= '0;  // wrap after the last stage pass
    else if (Iterate)
      iterCnt <= iterCnt + 1'b1;
    else
      iterCnt <= '0;
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Done  <= 1'b0;
      Ready <= 1'b1;  // idle after reset
    end
    else if (Start)
    begin
      Done  <= 1'b0;
      Ready <= 1'b0;
    end
    else
    begin
      Done <= lastIter;  // single cycle
      if (lastIter)
        Ready <= 1'b1;
    end
  end

endmodule

// File: rtl/divTop.sv
////////////////////////////////////////////////////////////////////////////
// top level of the mantissa and exponent divider
// control, four-cell iteration stage, quotient registers with rounding
// and the biased exponent path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module divTop import divPkg::*; #(
  parameter int unsigned MantW = divPkg::MantW,
  parameter int unsigned ExpW  = divPkg::ExpW
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             Start,
  input  logic [MantW-1:0] Numerator,     // hidden bit set
  input  logic [MantW-1:0] Denominator,   // hidden bit set
  input  logic [ExpW-1:0]  ExpNum,
  input  logic [ExpW-1:0]  ExpDen,
  output logic             Ready,
  output logic             Done,
  output logic [MantW-1:0] MantResult,
  output logic [ExpW+1:0]  ExpResult
);

  localparam int unsigned NumIter = MantW / BitsPerCycle;

  logic loadPulse;
  logic iterate;
  logic divBusy;

  divIterIf #(.MantW(MantW)) iterIf ();

  divCtrl #(.NumIter(NumIter)) i_ctrl (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .Start     (Start),
    .LoadPulse (loadPulse),
    .Iterate   (iterate),
    .DivBusy   (divBusy),
    .Ready     (Ready),
    .Done      (Done)
  );

  // operands go straight into the cells
  iterStage #(.MantW(MantW)) i_stage (
    .Numerator   (Numerator),
    .Denominator (Denominator),
    .Iter        (iterIf.stage)
  );

  quotientUnit #(.MantW(MantW)) i_quot (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .Iterate    (iterate),
    .LoadPulse  (loadPulse),
    .DivBusy    (divBusy),
    .Iter       (iterIf.quot),
    .MantResult (MantResult)
  );

  expUnit #(.ExpW(ExpW)) i_exp (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .LoadPulse (loadPulse),
    .ExpNum    (ExpNum),
    .ExpDen    (ExpDen),
    .ExpResult (ExpResult)
  );

endmodule

// File: rtl/expUnit.sv
////////////////////////////////////////////////////////////////////////////
// biased result exponent of the division
// ExpNum - ExpDen + bias, two extra bits for sign and overflow
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module expUnit import divPkg::*; #(
  parameter int unsigned ExpW = divPkg::ExpW
) (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            LoadPulse,
  input  logic [ExpW-1:0] ExpNum,
  input  logic [ExpW-1:0] ExpDen,
  output logic [ExpW+1:0] ExpResult  // two's complement
);

  localparam int unsigned     ResW        = ExpW + 2;
  localparam logic [ResW-1:0] BiasPlusOne = ResW'(ExpBias + 1);

  logic [ResW-1:0] numExt;
  logic [ResW-1:0] denCmp;
  logic [ResW-1:0] expDiff;

  assign numExt  = {2'b00, ExpNum};     // exponent fields are unsigned
  assign denCmp  = ~{2'b00, ExpDen};    // -ExpDen - 1
  assign expDiff = numExt + denCmp + BiasPlusOne;  // +1 restores the negation

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
      ExpResult <= '0;
    else if (LoadPulse)
      ExpResult <= expDiff;  // held for the rest of the operation
  end

endmodule

// File: runSim.sh
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module divTb \
  --Mdir obj_dir -o simDiv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simDiv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: testbench/divTb.sv
////////////////////////////////////////////////////////////////////////////
// testbench of the mantissa and exponent divider
// clock, reset, directed tests, reference model, check task, timeout
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module divTb import divPkg::*; ();

  localparam int unsigned NumIter  = MantW / BitsPerCycle;
  localparam int          RandSeed = 69703;
  // twice the cycles of about 45 operations of NumIter + 5 cycles plus reset and idle time
  localparam int          TimeoutCycles = 2 * (45 * (NumIter + 5) + 20);

  logic             Clk_CI;
  logic             Rst_RBI;
  logic             Start;
  logic [MantW-1:0] Numerator;
  logic [MantW-1:0] Denominator;
  logic [ExpW-1:0]  ExpNum;
  logic [ExpW-1:0]  ExpDen;
  logic             Ready;
  logic             Done;
  logic [MantW-1:0] MantResult;
  logic [ExpW+1:0]  ExpResult;

  divTop #(.MantW(MantW), .ExpW(ExpW)) i_dut (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #10 Clk_CI = ~Clk_CI;  // 20 ns period
  end

  initial
  begin : timeoutWatch
    int cycleCnt;
    cycleCnt = 0;
    while (cycleCnt < TimeoutCycles)
    begin
      @(posedge Clk_CI);
      cycleCnt++;
    end
    $display("Timeout: Done never came within %0d clock cycles", TimeoutCycles);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped by the cycle limit");
  end

  task automatic checkEq(input string name, input logic [63:0] expVal, input logic [63:0] actVal);
    if (expVal !== actVal)
    begin
      $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, expVal, actVal);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // floor(n * 2^MantW / d) carries one bit past the result
  function automatic logic [63:0] scaledQuot(input logic [MantW-1:0] n,
                                             input logic [MantW-1:0] d);
    return (64'(n) << MantW) / 64'(d);
  endfunction

  function automatic logic [MantW-1:0] refMant(input logic [MantW-1:0] n,
                                               input logic [MantW-1:0] d);
    logic [63:0] trunc;
    logic [63:0] rounded;
    trunc   = scaledQuot(n, d) >> 1;
    rounded = trunc + (scaledQuot(n, d) & 64'd1);
    if ((rounded >> MantW) != 64'd0)
      return trunc[MantW-1:0];  // no room for the increment
    return rounded[MantW-1:0];
  endfunction

  function automatic logic [ExpW+1:0] refExp(input logic [ExpW-1:0] en,
                                             input logic [ExpW-1:0] ed);
    int e;
    e = int'(en) - int'(ed) + int'(ExpBias);
    return e[ExpW+1:0];
  endfunction

  function automatic logic [MantW-1:0] randMant();
    logic [MantW-1:0] m;
    m = MantW'($urandom);
    m[MantW-1] = 1'b1;  // hidden bit
    return m;
  endfunction

  // one division with latency and Ready checked on the way
  task automatic runDiv(input string name, input logic [MantW-1:0] n, input logic [MantW-1:0] d,
                        input logic [ExpW-1:0] en, input logic [ExpW-1:0] ed);
    int waitCnt;
    @(negedge Clk_CI);
    while (Ready !== 1'b1)
    begin
      @(negedge Clk_CI);
    end
    @(posedge Clk_CI);
    Start       <= 1'b1;
    Numerator   <= n;
    Denominator <= d;
    ExpNum      <= en;
    ExpDen      <= ed;
    @(posedge Clk_CI);  // sampling edge
    Start <= 1'b0;
    @(negedge Clk_CI);
    waitCnt = 1;
    while (Done !== 1'b1)
    begin
      checkEq({name, " ready low"}, 64'(0), 64'(Ready));
      @(negedge Clk_CI);
      waitCnt++;
    end
    checkEq({name, " done cycle"}, 64'(NumIter + 1), 64'(waitCnt));
    checkEq({name, " ready back"}, 64'(1), 64'(Ready));
    checkEq({name, " mantissa"}, 64'(refMant(n, d)), 64'(MantResult));
    checkEq({name, " exponent"}, 64'(refExp(en, ed)), 64'(ExpResult));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testReset();
    repeat (3)
    begin
      @(negedge Clk_CI);
      checkEq("reset ready", 64'(1), 64'(Ready));
      checkEq("reset done", 64'(0), 64'(Done));
      checkEq("reset mantissa", 64'(0), 64'(MantResult));
      checkEq("reset exponent", 64'(0), 64'(ExpResult));
    end
  endtask

  task automatic testTiming();
    runDiv("timing", 24'hC00000, 24'h800000, 8'd127, 8'd127);
    @(negedge Clk_CI);
    checkEq("timing done width", 64'(0), 64'(Done));
    checkEq("timing ready idle", 64'(1), 64'(Ready));
  endtask

  task automatic testSimple();
    runDiv("equal", 24'hC00000, 24'hC00000, 8'd127, 8'd127);
    runDiv("one and a half", 24'hC00000, 24'h800000, 8'd130, 8'd127);
    runDiv("two thirds", 24'h800000, 24'hC00000, 8'd100, 8'd90);
    runDiv("exp negative", 24'h900000, 24'hA00000, 8'd0, 8'd255);
    runDiv("exp overflow", 24'hF00000, 24'h880000, 8'd255, 8'd0);
  endtask

  task automatic testRounding();
    logic [MantW-1:0] n;
    logic [MantW-1:0] d;
    int               found;
    found = 0;
    while (found < 3)  // pick pairs whose next quotient bit is set
    begin
      n = randMant();
      d = randMant();
      if ((scaledQuot(n, d) & 64'd1) == 64'd1)
      begin
        found++;
        runDiv($sformatf("round up %0d", found), n, d, 8'd127, 8'd126);
      end
    end
    runDiv("all ones", '1, {1'b1, {(MantW-1){1'b0}}}, 8'd127, 8'd127);
  endtask

  task automatic testRandom();
    for (int i = 0; i < 30; i++)
    begin
      runDiv($sformatf("random %0d", i), randMant(), randMant(), ExpW'($urandom), ExpW'($urandom));
    end
  endtask

  task automatic testHold();
    logic [MantW-1:0] mantHeld;
    logic [ExpW+1:0]  expHeld;
    runDiv("hold", 24'hA00000, 24'hE00000, 8'd140, 8'd100);
    mantHeld = MantResult;
    expHeld  = ExpResult;
    @(posedge Clk_CI);
    Numerator   <= randMant();  // new operands must not leak into the result
    Denominator <= randMant();
    ExpNum      <= ExpW'($urandom);
    ExpDen      <= ExpW'($urandom);
    repeat (10)
    begin
      @(negedge Clk_CI);
      checkEq("hold mantissa", 64'(mantHeld), 64'(MantResult));
      checkEq("hold exponent", 64'(expHeld), 64'(ExpResult));
      checkEq("hold done", 64'(0), 64'(Done));
    end
  endtask

  initial
  begin
    void'($urandom(RandSeed));
    Rst_RBI     = 1'b0;
    Start       = 1'b0;
    Numerator   = '0;
    Denominator = '0;
    ExpNum      = '0;
    ExpDen      = '0;
    repeat (3) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;
    testReset();
    testTiming();
    testSimple();
    testRounding();
    testRandom();
    testHold();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: vlog.f
common/divPkg.sv
common/divIterIf.sv
rtl/divCtrl.sv
rtl/expUnit.sv
divider/iterStage.sv
divider/quotientUnit.sv
rtl/divTop.sv
testbench/divTb.sv
